// File: source/controlUnit_defines.svh
// Control unit widths and flag positions
`ifndef CONTROL_UNIT_DEFINES_SVH
`define CONTROL_UNIT_DEFINES_SVH

// Instruction field widths
`define OPCODE_WIDTH 5
`define COND_WIDTH 3

// Status register
`define FLAG_WIDTH 4

// Flag bit positions in the status register
`define FLAG_C 0
`define FLAG_Z 1
`define FLAG_N 2
`define FLAG_V 3

`endif

// File: source/cpuControlPkg.sv
// Control unit shared types
`include "controlUnit_defines.svh"

package cpuControlPkg;

   typedef enum logic [`OPCODE_WIDTH-1:0] {
      ADD = 5'h00, ADDI = 5'h01, ADC = 5'h02,
      SUB = 5'h04, SUBI = 5'h05, CMP = 5'h06, CMPI = 5'h07,
      AND = 5'h08, OR = 5'h09, XOR = 5'h0a, NOT = 5'h0b,
      LSL = 5'h0c, LSR = 5'h0d, ASR = 5'h0e,
      LDW = 5'h10, STW = 5'h11,
      BRANCH = 5'h18, INTERRUPT = 5'h19
   } opcodeT;

   typedef enum logic [`COND_WIDTH-1:0] {
      BR, BNE, BE, BLT, BGE, BWL, RET, JMP
   } condCodeT;

   // Sub-function numbers of the INTERRUPT opcode
   localparam logic [`COND_WIDTH-1:0] SubReti = 3'd0;
   localparam logic [`COND_WIDTH-1:0] SubEnai = 3'd1;
   localparam logic [`COND_WIDTH-1:0] SubDisi = 3'd2;

   typedef struct packed {
      opcodeT   opcode;
      condCodeT code;   // Branch code or sub-function
   } instructionT;

   typedef enum logic [1:0] {StateFetch, StateExecute, StateInterrupt} majorStateT;
   typedef enum logic [2:0] {Cycle0, Cycle1, Cycle2, Cycle3, Cycle4} subCycleT;

   typedef struct packed {
      majorStateT majorState;
      subCycleT   subCycle;
   } sequenceT;

   typedef enum logic [3:0] {
      FnPass, FnAdd, FnAdc, FnSub, FnAnd, FnOr, FnXor, FnNot,
      FnLsl, FnLsr, FnAsr, FnInc, FnDec
   } aluFunctionT;

   // All zero encodings are the idle defaults
   typedef enum logic [1:0] {Op1Rd1, Op1Pc} op1SelectT;
   typedef enum logic [1:0] {Op2Imm, Op2Rd2} op2SelectT;
   typedef enum logic [1:0] {ImmLong, ImmShort} immSelectT;
   typedef enum logic [1:0] {Pc1, PcAluOut, PcSysbus, PcInt} pcSelectT;
   typedef enum logic [1:0] {WdAlu, WdSys} wdSelectT;
   typedef enum logic [1:0] {Rs1Ra, Rs1Rd, Rs1Sp} rs1SelectT;
   typedef enum logic [1:0] {RwRd, RwSp} rwSelectT;

   typedef struct packed {
      aluFunctionT aluFunction;
      op1SelectT   op1Sel;
      op2SelectT   op2Sel;
      immSelectT   immSel;
      pcSelectT    pcSel;
      wdSelectT    wdSel;
      rs1SelectT   rs1Sel;
      rwSelectT    rwSel;
      logic        aluEn;   // ALU register onto sysbus
      logic        aluWe;
      logic        lrEn;
      logic        lrWe;
      logic        pcEn;    // PC onto sysbus
      logic        pcWe;
      logic        irWe;
      logic        regWe;
   } datapathControlT;

   typedef struct packed {
      logic memEn;   // Pad direction
      logic nWE;
      logic nOE;
      logic nME;
      logic enb;
      logic ale;
   } busControlT;

   typedef struct packed {
      logic enableInt;
      logic disableInt;
      logic clear;
      logic leaveService;
   } intControlT;

endpackage

// File: source/cycleSequencer.sv
// Major state and sub-cycle sequencer
`timescale 1ns/1ps

module cycleSequencer import cpuControlPkg::*; (
   input  logic     Clock,
   input  logic     nReset,
   input  logic     nWait,
   input  logic     multiCycle,
   input  logic     intReq,
   output sequenceT state
);

   sequenceT afterInstr;

   // Where to go once an instruction has finished
   assign afterInstr = intReq ? sequenceT'{StateInterrupt, Cycle0}
                              : sequenceT'{StateFetch, Cycle0};

   always_ff @(posedge Clock or negedge nReset) begin
      if (!nReset) begin
         state <= sequenceT'{StateFetch, Cycle0};
      end else begin
         case (state.majorState)
            StateFetch: begin
               case (state.subCycle)
                  Cycle0: state.subCycle <= Cycle1;
                  Cycle1: state.subCycle <= Cycle2;
                  Cycle2: begin
                     if (nWait)   // Stretch instruction read
                        state.subCycle <= Cycle3;
                  end
                  default: state <= sequenceT'{StateExecute, Cycle0};
               endcase
            end
            StateExecute: begin
               case (state.subCycle)
                  Cycle0: begin
                     if (multiCycle)
                        state.subCycle <= Cycle1;
                     else
                        state <= afterInstr;   // Single cycle done
                  end
                  Cycle1: state.subCycle <= Cycle2;
                  Cycle2: state.subCycle <= Cycle3;
                  Cycle3: begin
                     if (nWait)   // Data phase held by memory
                        state.subCycle <= Cycle4;
                  end
                  default: state <= afterInstr;
               endcase
            end
            default: begin
               // Interrupt entry always runs all five cycles
               case (state.subCycle)
                  Cycle0: state.subCycle <= Cycle1;
                  Cycle1: state.subCycle <= Cycle2;
                  Cycle2: state.subCycle <= Cycle3;
                  Cycle3: state.subCycle <= Cycle4;
                  default: state <= sequenceT'{StateFetch, Cycle0};
               endcase
            end
         endcase
      end
   end

endmodule

// File: source/interruptUnit.sv
// Interrupt request and service flags
`timescale 1ns/1ps

module interruptUnit import cpuControlPkg::*; (
   input  logic       Clock,
   input  logic       nReset,
   input  logic       nIrq,
   input  intControlT intCtl,
   input  sequenceT   state,
   output logic       intReq
);

   logic irqSync1;
   logic irqSync2;
   logic intEnabled;
   logic inService;
   logic enterService;

   assign enterService = (state.majorState == StateInterrupt) && (state.subCycle == Cycle0);

   always_ff @(posedge Clock or negedge nReset) begin
      if (!nReset) begin
         irqSync1   <= 1'b0;
         irqSync2   <= 1'b0;
         intReq     <= 1'b0;
         intEnabled <= 1'b0;
         inService  <= 1'b0;
      end else begin
         irqSync1 <= ~nIrq;   // Pin is active low
         irqSync2 <= irqSync1;
         // Latch a request until the entry sequence clears it
         intReq <= (irqSync2 & intEnabled & ~inService) | (intReq & ~intCtl.clear);

         if (intCtl.enableInt)
            intEnabled <= 1'b1;
         else if (intCtl.disableInt)
            intEnabled <= 1'b0;

         // Blocks re-entry on a held request
         if (enterService)
            inService <= 1'b1;
         else if (intCtl.leaveService)
            inService <= 1'b0;
      end
   end

endmodule

// File: source/controlDecoder.sv
// Control word decoder and status register
`timescale 1ns/1ps
`include "controlUnit_defines.svh"

module controlDecoder import cpuControlPkg::*; (
   input  logic                   Clock,
   input  logic                   nReset,
   input  sequenceT               state,
   input  instructionT            instruction,
   input  logic [`FLAG_WIDTH-1:0] aluFlags,
   output datapathControlT        datapath,
   output busControlT             bus,
   output intControlT             intCtl,
   output logic                   multiCycle,
   output logic [`FLAG_WIDTH-1:0] statusFlags
);

   opcodeT                  opcode;
   logic [`COND_WIDTH-1:0]  subFunc;
   logic                    branchTaken;
   logic                    statusWe;
   logic                    execute0;

   assign opcode   = instruction.opcode;
   assign subFunc  = instruction.code;
   assign execute0 = (state.majorState == StateExecute) && (state.subCycle == Cycle0);

   assign multiCycle = execute0 && ((opcode inside {LDW, STW}) ||
                       (opcode == INTERRUPT && subFunc == SubReti));

   always_comb begin
      case (instruction.code)
         BNE:     branchTaken = !statusFlags[`FLAG_Z];
         BE:      branchTaken = statusFlags[`FLAG_Z];
         BLT:     branchTaken = statusFlags[`FLAG_N] != statusFlags[`FLAG_V];
         BGE:     branchTaken = statusFlags[`FLAG_N] == statusFlags[`FLAG_V];
         default: branchTaken = 1'b1;   // BR and BWL
      endcase
   end

   function automatic aluFunctionT aluFunctionFor(opcodeT op);
      case (op)
         ADD, ADDI:           return FnAdd;
         ADC:                 return FnAdc;
         SUB, SUBI, CMP, CMPI: return FnSub;
         AND:                 return FnAnd;
         OR:                  return FnOr;
         XOR:                 return FnXor;
         NOT:                 return FnNot;
         LSL:                 return FnLsl;
         LSR:                 return FnLsr;
         ASR:                 return FnAsr;
         default:             return FnPass;
      endcase
   endfunction

   always_comb begin
      datapath = '0;   // Pass, Rd1, long immediate, PC+1, no enables
      bus      = '0;
      bus.nME  = 1'b1;
      bus.nWE  = 1'b1;
      bus.nOE  = 1'b1;
      intCtl   = '0;
      statusWe = 1'b0;
      case (state.majorState)
         StateFetch: begin
            case (state.subCycle)
               Cycle0: begin bus.ale = 1'b1; datapath.pcEn = 1'b1; end   // PC as address
               Cycle1: begin bus.nME = 1'b0; bus.nOE = 1'b0; bus.memEn = 1'b1; end
               Cycle2: begin
                  bus.nME = 1'b0; bus.nOE = 1'b0; bus.memEn = 1'b1; bus.enb = 1'b1;
               end
               default: begin bus.memEn = 1'b1; datapath.irWe = 1'b1; end
            endcase
         end
         StateExecute: begin
            case (state.subCycle)
               Cycle0: begin
                  case (opcode)
                     LDW, STW: begin   // Effective address into ALU register
                        datapath.aluFunction = FnAdd;
                        datapath.immSel      = ImmShort;
                        datapath.aluEn       = 1'b1;
                        datapath.aluWe       = 1'b1;
                     end
                     BRANCH: begin
                        datapath.pcWe = 1'b1;
                        case (instruction.code)
                           RET: begin datapath.lrEn = 1'b1; datapath.pcSel = PcSysbus; end
                           JMP: begin
                              datapath.aluFunction = FnAdd;
                              datapath.immSel      = ImmShort;
                              datapath.aluEn       = 1'b1;
                              datapath.pcSel       = PcAluOut;
                           end
                           default: begin   // PC relative
                              datapath.aluFunction = FnAdd;
                              datapath.op1Sel      = Op1Pc;
                              datapath.aluEn       = 1'b1;
                              datapath.pcSel       = branchTaken ? PcAluOut : Pc1;
                              datapath.lrWe        = branchTaken && instruction.code == BWL;
                           end
                        endcase
                     end
                     INTERRUPT: begin
                        if (subFunc == SubReti) begin   // Fetch SP for the pop
                           datapath.rs1Sel = Rs1Sp;
                           datapath.aluEn  = 1'b1;
                           datapath.aluWe  = 1'b1;
                        end else begin
                           datapath.pcEn     = 1'b1;
                           datapath.pcWe     = 1'b1;
                           intCtl.enableInt  = subFunc == SubEnai;
                           intCtl.disableInt = subFunc == SubDisi;
                        end
                     end
                     default: begin   // Single cycle ALU group
                        datapath.aluFunction = aluFunctionFor(opcode);
                        if (opcode inside {ADD, ADC, SUB, CMP, AND, OR, XOR})
                           datapath.op2Sel = Op2Rd2;
                        else
                           datapath.immSel = ImmShort;
                        datapath.pcEn  = 1'b1;
                        datapath.pcWe  = 1'b1;
                        datapath.regWe = !(opcode inside {CMP, CMPI});
                        statusWe       = 1'b1;
                     end
                  endcase
               end
               Cycle1: begin   // Address phase
                  bus.ale        = 1'b1;
                  datapath.aluEn = 1'b1;
                  if (opcode == INTERRUPT) begin
                     datapath.rs1Sel      = Rs1Sp;
                     datapath.aluFunction = FnInc;
                  end
               end
               Cycle2: begin
                  bus.nME = 1'b0;
                  if (opcode == STW) begin   // Store data into ALU register
                     datapath.rs1Sel = Rs1Rd;
                     datapath.aluEn  = 1'b1;
                     datapath.aluWe  = 1'b1;
                  end else begin
                     bus.nOE   = 1'b0;
                     bus.memEn = 1'b1;
                  end
               end
               Cycle3: begin
                  bus.nME = 1'b0;
                  if (opcode == STW) begin
                     bus.nWE        = 1'b0;
                     datapath.aluEn = 1'b1;
                  end else begin
                     bus.nOE   = 1'b0;
                     bus.memEn = 1'b1;
                     bus.enb   = 1'b1;
                  end
               end
               default: begin
                  datapath.pcWe = 1'b1;
                  case (opcode)
                     LDW: begin
                        bus.memEn      = 1'b1;
                        datapath.wdSel = WdSys;
                        datapath.regWe = 1'b1;
                     end
                     STW: datapath.aluEn = 1'b1;
                     default: begin   // RETI restores PC and bumps SP
                        bus.memEn            = 1'b1;
                        datapath.pcSel       = PcSysbus;
                        datapath.rs1Sel      = Rs1Sp;
                        datapath.rwSel       = RwSp;
                        datapath.aluFunction = FnInc;
                        datapath.regWe       = 1'b1;
                        intCtl.leaveService  = 1'b1;
                     end
                  endcase
               end
            endcase
         end
         default: begin
            // Interrupt entry pushes the PC
            datapath.rs1Sel = Rs1Sp;
            case (state.subCycle)
               Cycle0: begin
                  datapath.aluFunction = FnDec;
                  datapath.rwSel       = RwSp;
                  datapath.regWe       = 1'b1;
                  datapath.aluEn       = 1'b1;
                  datapath.aluWe       = 1'b1;
               end
               Cycle1: begin bus.ale = 1'b1; datapath.aluEn = 1'b1; end
               Cycle2: bus.nME = 1'b0;
               Cycle3: begin bus.nME = 1'b0; bus.nWE = 1'b0; datapath.pcEn = 1'b1; end
               default: begin
                  datapath.pcSel = PcInt;
                  datapath.pcWe  = 1'b1;
                  intCtl.clear   = 1'b1;
               end
            endcase
         end
      endcase
   end

   always_ff @(posedge Clock or negedge nReset) begin
      if (!nReset)
         statusFlags <= '0;
      else if (statusWe)
         statusFlags <= aluFlags;
   end

endmodule

// File: source/controlUnit.sv
// Processor control unit top level
`timescale 1ns/1ps
`include "controlUnit_defines.svh"

module controlUnit import cpuControlPkg::*; (
   input  logic                   Clock,
   input  logic                   nReset,
   input  instructionT            instruction,   // From external IR
   input  logic [`FLAG_WIDTH-1:0] aluFlags,
   input  logic                   nWait,
   input  logic                   nIrq,
   output datapathControlT        datapath,
   output busControlT             bus,
   output logic [`FLAG_WIDTH-1:0] statusFlags
);

   sequenceT   state;
   intControlT intCtl;
   logic       multiCycle;
   logic       intReq;

   cycleSequencer cycleSequencer_inst (
      .Clock      (Clock),
      .nReset     (nReset),
      .nWait      (nWait),
      .multiCycle (multiCycle),
      .intReq     (intReq),
      .state      (state)
   );

   interruptUnit interruptUnit_inst (
      .Clock  (Clock),
      .nReset (nReset),
      .nIrq   (nIrq),
      .intCtl (intCtl),
      .state  (state),
      .intReq (intReq)
   );

   controlDecoder controlDecoder_inst (
      .Clock       (Clock),
      .nReset      (nReset),
      .state       (state),
      .instruction (instruction),
      .aluFlags    (aluFlags),
      .datapath    (datapath),
      .bus         (bus),
      .intCtl      (intCtl),
      .multiCycle  (multiCycle),
      .statusFlags (statusFlags)
   );

endmodule

// File: bench/controlUnit_checker.sv
// Control unit bus and sequencing assertions
`timescale 1ns/1ps

module controlUnit_checker import cpuControlPkg::*; (
   input logic            Clock,
   input logic            nReset,
   input sequenceT        state,
   input datapathControlT datapath,
   input busControlT      bus
);

   // Address latch and memory select never overlap
   aleBeforeSelect: assert property (@(posedge Clock) disable iff (!nReset)
      !(bus.ale && !bus.nME))
      else $error("nME low while ALE high");

   irWriteInFetch3: assert property (@(posedge Clock) disable iff (!nReset)
      datapath.irWe |-> (state.majorState == StateFetch && state.subCycle == Cycle3))
      else $error("IrWe outside fetch cycle3");

   noFetchCycle4: assert property (@(posedge Clock) disable iff (!nReset)
      !(state.majorState == StateFetch && state.subCycle == Cycle4))
      else $error("Fetch reached cycle4");

   // One PC update per instruction or entry
   pcWriteSingle: assert property (@(posedge Clock) disable iff (!nReset)
      datapath.pcWe |=> !datapath.pcWe)
      else $error("PcWe high in two consecutive cycles");

endmodule

bind controlUnit controlUnit_checker controlUnit_checker_inst (
   .Clock    (Clock),
   .nReset   (nReset),
   .state    (state),
   .datapath (datapath),
   .bus      (bus)
);

// File: bench/controlUnitTb.sv
// Control unit testbench
`timescale 1ns/1ps
`include "controlUnit_defines.svh"

module controlUnitTb import cpuControlPkg::*; ();

   typedef struct packed {
      instructionT            instr;
      logic [`FLAG_WIDTH-1:0] flags;      // Presented on aluFlags
      aluFunctionT            aluFn;      // Execute cycle0
      logic                   regWe;      // Last execute cycle
      logic                   statusWr;
      pcSelectT               pcSel;      // Last execute cycle
      logic                   lrWe;
      logic [2:0]             execLen;    // Without waits
      logic                   nIrq;
      logic                   intAfter;   // Interrupt entry follows
   } rowT;

   localparam int NumRows = 30;
   localparam rowT rows [NumRows] = '{
      '{'{ADD, BR},        4'b0001, FnAdd,  1, 1, Pc1,      0, 1, 1, 0},
      '{'{CMP, BR},        4'b0010, FnSub,  0, 1, Pc1,      0, 1, 1, 0},
      '{'{BRANCH, BNE},    4'b0000, FnAdd,  0, 0, Pc1,      0, 1, 1, 0},   // Z set
      '{'{BRANCH, BE},     4'b0000, FnAdd,  0, 0, PcAluOut, 0, 1, 1, 0},
      '{'{CMPI, BR},       4'b0100, FnSub,  0, 1, Pc1,      0, 1, 1, 0},
      '{'{BRANCH, BLT},    4'b0000, FnAdd,  0, 0, PcAluOut, 0, 1, 1, 0},   // N without V
      '{'{BRANCH, BGE},    4'b0000, FnAdd,  0, 0, Pc1,      0, 1, 1, 0},
      '{'{SUBI, BR},       4'b1100, FnSub,  1, 1, Pc1,      0, 1, 1, 0},
      '{'{BRANCH, BGE},    4'b0000, FnAdd,  0, 0, PcAluOut, 0, 1, 1, 0},
      '{'{BRANCH, BNE},    4'b0000, FnAdd,  0, 0, PcAluOut, 0, 1, 1, 0},   // Z clear
      '{'{BRANCH, BE},     4'b0000, FnAdd,  0, 0, Pc1,      0, 1, 1, 0},
      '{'{BRANCH, BLT},    4'b0000, FnAdd,  0, 0, Pc1,      0, 1, 1, 0},   // N with V
      '{'{BRANCH, BWL},    4'b0000, FnAdd,  0, 0, PcAluOut, 1, 1, 1, 0},
      '{'{BRANCH, BR},     4'b0000, FnAdd,  0, 0, PcAluOut, 0, 1, 1, 0},
      '{'{BRANCH, JMP},    4'b0000, FnAdd,  0, 0, PcAluOut, 0, 1, 1, 0},
      '{'{BRANCH, RET},    4'b0000, FnPass, 0, 0, PcSysbus, 0, 1, 1, 0},
      '{'{LDW, BR},        4'b0000, FnAdd,  1, 0, Pc1,      0, 5, 1, 0},
      '{'{STW, BR},        4'b0000, FnAdd,  0, 0, Pc1,      0, 5, 1, 0},
      '{'{XOR, BR},        4'b0010, FnXor,  1, 1, Pc1,      0, 1, 1, 0},
      '{'{ASR, BR},        4'b1000, FnAsr,  1, 1, Pc1,      0, 1, 1, 0},
      '{'{ADD, BR},        4'b0001, FnAdd,  1, 1, Pc1,      0, 1, 0, 0},   // Request while disabled
      '{'{OR, BR},         4'b0000, FnOr,   1, 1, Pc1,      0, 1, 0, 0},
      '{'{INTERRUPT, BNE}, 4'b1111, FnPass, 0, 0, Pc1,      0, 1, 0, 0},   // ENAI
      '{'{AND, BR},        4'b0010, FnAnd,  1, 1, Pc1,      0, 1, 0, 1},
      '{'{LSL, BR},        4'b0000, FnLsl,  1, 1, Pc1,      0, 1, 0, 0},   // Still in service
      '{'{INTERRUPT, BR},  4'b1111, FnPass, 1, 0, PcSysbus, 0, 5, 0, 0},   // RETI
      '{'{NOT, BR},        4'b0001, FnNot,  1, 1, Pc1,      0, 1, 1, 1},
      '{'{INTERRUPT, BR},  4'b0000, FnPass, 1, 0, PcSysbus, 0, 5, 1, 0},
      '{'{INTERRUPT, BE},  4'b0000, FnPass, 0, 0, Pc1,      0, 1, 1, 0},   // DISI
      '{'{LSR, BR},        4'b0100, FnLsr,  1, 1, Pc1,      0, 1, 1, 0}
   };

   logic                   Clock;
   logic                   nReset;
   instructionT            instruction;
   logic [`FLAG_WIDTH-1:0] aluFlags;
   logic                   nWait;
   logic                   nIrq;
   datapathControlT        datapath;
   busControlT             bus;
   logic [`FLAG_WIDTH-1:0] statusFlags;

   int          errors = 0;
   int          cycleCount = 0;
   int          cycleLimit = 1000;
   int          waitLeft = 0;
   logic [31:0] rngState = 32'hca7d33cf;

   controlUnit controlUnit_inst (.*);

   initial begin
      Clock = 1'b0;
      forever #2 Clock = ~Clock;
   end

   always @(posedge Clock) begin
      cycleCount++;
      if (cycleCount > cycleLimit) begin
         $display("Timeout after %0d cycles, the DUT stopped making progress", cycleCount);
         $display("*** FAILED ***");
         $finish;
      end
   end

   function automatic logic [31:0] xorshift(input logic [31:0] x);
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   function automatic int drawWaits();
      rngState = xorshift(rngState);
      return int'(rngState[1:0]);   // 0 to 3
   endfunction

   task automatic checkValue(input string name, input int expected, input int actual);
      if (expected != actual) begin
         errors++;
         $display("FAIL time=%0t %s expected=%0h actual=%0h", $time, name, expected, actual);
      end
   endtask

   function automatic logic isFetch0();
      return bus.ale && datapath.pcEn;
   endfunction

   function automatic logic isInt0();
      return datapath.regWe && datapath.rwSel == RwSp && datapath.aluFunction == FnDec;
   endfunction

   // Memory model holds nWait low in data phases
   task automatic nextCycle();
      @(negedge Clock);
      if ((bus.enb || (!bus.nWE && datapath.aluEn)) && waitLeft > 0) begin
         nWait = 1'b0;
         waitLeft--;
      end else begin
         nWait = 1'b1;
      end
   endtask

   task automatic runRow(input rowT r);
      int              fetchWaits;
      int              execWaits;
      int              fetchLen;
      int              execLen;
      int              intLen;
      logic [3:0]      prevFlags;
      aluFunctionT     firstFn;
      datapathControlT last;
      logic            intSeen;
      logic            pcIntSeen;
      fetchWaits = drawWaits();
      execWaits  = drawWaits();
      waitLeft   = fetchWaits;
      fetchLen   = 1;
      while (!datapath.irWe) begin
         nextCycle();
         fetchLen++;
      end
      checkValue("fetchLength", 4 + fetchWaits, fetchLen);
      prevFlags   = statusFlags;
      instruction = r.instr;
      aluFlags    = r.flags;
      nIrq        = r.nIrq;
      waitLeft    = execWaits;
      nextCycle();
      firstFn = datapath.aluFunction;
      last    = datapath;
      execLen = 0;
      while (!(isFetch0() || isInt0())) begin
         execLen++;
         last = datapath;
         if (datapath.pcSel == PcInt) begin
            errors++;
            $display("Interrupt vector selected during an execute cycle at %0t", $time);
         end
         nextCycle();
         if (execLen == 1)
            checkValue("statusFlags", int'(r.statusWr ? r.flags : prevFlags),
                       int'(statusFlags));
      end
      checkValue("execLength", int'(r.execLen) + (r.execLen > 1 ? execWaits : 0), execLen);
      checkValue("aluFunction", int'(r.aluFn), int'(firstFn));
      checkValue("regWe", int'(r.regWe), int'(last.regWe));
      checkValue("pcSel", int'(r.pcSel), int'(last.pcSel));
      checkValue("lrWe", int'(r.lrWe), int'(last.lrWe));
      if (r.instr.opcode == LDW)
         checkValue("wdSel", int'(WdSys), int'(last.wdSel));
      intSeen   = isInt0();
      intLen    = 0;
      pcIntSeen = 1'b0;
      while (!isFetch0()) begin
         intLen++;
         pcIntSeen = pcIntSeen || (datapath.pcWe && datapath.pcSel == PcInt);
         nextCycle();
      end
      checkValue("interruptEntry", int'(r.intAfter), int'(intSeen));
      if (intSeen) begin
         checkValue("interruptLength", 5, intLen);
         checkValue("pcIntWrite", 1, int'(pcIntSeen));
      end
   endtask

   initial begin
      nReset      = 1'b0;
      instruction = '{ADD, BR};
      aluFlags    = '0;
      nWait       = 1'b1;
      nIrq        = 1'b1;
      cycleLimit  = 16;
      foreach (rows[i])
         cycleLimit += 2 * (7 + int'(rows[i].execLen) + 3 + 5);   // Worst case per row
      repeat (16) begin
         @(negedge Clock);
         checkValue("nME", 1, int'(bus.nME));
         checkValue("irWe", 0, int'(datapath.irWe));
         checkValue("pcWe", 0, int'(datapath.pcWe));
         checkValue("regWe", 0, int'(datapath.regWe));
         checkValue("aluWe", 0, int'(datapath.aluWe));
         checkValue("lrWe", 0, int'(datapath.lrWe));
         checkValue("memEn", 0, int'(bus.memEn));
         checkValue("enb", 0, int'(bus.enb));
      end
      nReset = 1'b1;
      checkValue("ale", 1, int'(bus.ale));   // Fetch cycle0 after reset
      foreach (rows[i])
         runRow(rows[i]);
      $display("Errors: %0d", errors);
      if (errors == 0) begin
         $display("*** PASSED ***");
      end else begin
         $display("*** FAILED ***");
      end
      $finish;
   end

endmodule

// File: controlUnit.f
+incdir+source
source/cpuControlPkg.sv
source/cycleSequencer.sv
source/interruptUnit.sv
source/controlDecoder.sv
source/controlUnit.sv
bench/controlUnit_checker.sv
bench/controlUnitTb.sv

// File: run.sh
#!/bin/sh
# Build and run the control unit testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
   -f controlUnit.f \
   --top-module controlUnitTb \
   -o controlUnitSim

./obj_dir/controlUnitSim | tee sim.log

if grep -qF "*** PASSED ***" sim.log; then
   exit 0
else
   exit 1
fi
